//--- src/mf_params_pkg.sv
`default_nettype none

// default sizes for the matched filter datapath
package mf_params_pkg;

    // width of one signed ADC sample
    localparam int INBITS = 12;

    // samples delivered together on every clock
    localparam int NSAMP = 8;

    // filter length; taps beyond lane index reach into the previous block
    localparam int NTAPS = 8;

    // signed coefficient width
    localparam int COEF_BITS = 8;

    // lane sum width
    // 12x8 bit products are 20 bits, eight of them need 3 more
    localparam int ACC_BITS = 24;

    // width of the output downshift field
    localparam int SHIFT_BITS = 4;

    // width of the coefficient index carried in a config write
    localparam int CFG_IDX_BITS = 3;

    // width of the data field carried in a config write
    localparam int CFG_DATA_BITS = 16;

endpackage

`default_nettype wire

//--- src/mf_types_pkg.sv
`default_nettype none

// types shared between the configuration path and the datapath
package mf_types_pkg;

    import mf_params_pkg::*;

    // configuration opcodes, zero is left as a no-op
    typedef enum logic [3:0] {
        CFG_NOP           = 4'h0,
        CFG_SET_COEF      = 4'h1,
        CFG_SET_SHIFT     = 4'h2,
        CFG_CLEAR_HISTORY = 4'h3
    } mf_cfg_op_e;

    // one configuration write, qualified by cfg_we_i
    typedef struct packed {
        mf_cfg_op_e                op;
        logic [CFG_IDX_BITS-1:0]   idx;
        logic [CFG_DATA_BITS-1:0]  data;
    } mf_cfg_wr_s;

    typedef logic signed [INBITS-1:0]   mf_sample_t;
    typedef logic signed [ACC_BITS-1:0] mf_acc_t;

    // one block of samples, lane 0 is the oldest sample in time
    typedef struct packed {
        logic                     valid;
        mf_sample_t [NSAMP-1:0]   samples;
    } mf_sample_blk_s;

    // one block of full precision lane sums
    typedef struct packed {
        logic                  valid;
        mf_acc_t [NSAMP-1:0]   sums;
    } mf_acc_blk_s;

endpackage

`default_nettype wire

//--- src/mf_coef_regs.sv
`timescale 1ns/10ps
`default_nettype none

// configuration registers for the matched filter
// holds the tap coefficients and the output downshift, and turns a
// clear request into a single cycle strobe towards the history
module mf_coef_regs
    import mf_types_pkg::*;
#(
    parameter int NTAPS      = 8,
    parameter int COEF_BITS  = 8,
    parameter int SHIFT_BITS = 4
) (
    input  wire logic                               aclk,
    input  wire logic                               arst_n_i,
    input  wire logic                               cfg_we_i,
    input  wire mf_cfg_wr_s                         cfg_wr_i,
    output logic      [NTAPS-1:0][COEF_BITS-1:0]    coef_o,
    output logic      [SHIFT_BITS-1:0]              shift_o,
    output logic                                    clear_o
);

    logic [NTAPS-1:0][COEF_BITS-1:0] coef_q;
    logic [SHIFT_BITS-1:0]           shift_q;
    logic                            clear_q;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            coef_q  <= '0;
            shift_q <= '0;
            clear_q <= 1'b0;
        end else begin
            // clear is a strobe and drops unless requested again
            clear_q <= 1'b0;
            if (cfg_we_i) begin
                case (cfg_wr_i.op)
                    CFG_SET_COEF: begin
                        // only the low bits of data carry the coefficient
                        coef_q[cfg_wr_i.idx] <= cfg_wr_i.data[COEF_BITS-1:0];
                    end
                    CFG_SET_SHIFT: begin
                        shift_q <= cfg_wr_i.data[SHIFT_BITS-1:0];
                    end
                    CFG_CLEAR_HISTORY: begin
                        clear_q <= 1'b1;
                    end
                    default: begin
                        // nop and unknown opcodes leave the registers alone
                    end
                endcase
            end
        end
    end

    assign coef_o  = coef_q;
    assign shift_o = shift_q;
    assign clear_o = clear_q;

endmodule

`default_nettype wire

//--- src/mf_sample_history.sv
`timescale 1ns/10ps
`default_nettype none

// previous block storage
// lanes near the start of a block need samples from the block before,
// so the last accepted block is held here and shown next to the current one
module mf_sample_history
    import mf_types_pkg::*;
#(
    parameter int INBITS = 12,
    parameter int NSAMP  = 8
) (
    input  wire logic                           aclk,
    input  wire logic                           arst_n_i,
    input  wire logic                           clear_i,
    input  wire mf_sample_blk_s                 blk_i,
    output logic      [NSAMP-1:0][INBITS-1:0]   prev_o,
    output mf_sample_blk_s                      blk_o
);

    logic [NSAMP-1:0][INBITS-1:0] prev_q;

    // idle cycles keep the stored block, so gaps in the stream are invisible
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prev_q <= '0;
        end else if (clear_i) begin
            // clear wins over an accept in the same cycle
            prev_q <= '0;
        end else if (blk_i.valid) begin
            prev_q <= blk_i.samples;
        end
    end

    // window is the live input plus the stored block, no added latency
    assign blk_o  = blk_i;
    assign prev_o = prev_q;

endmodule

`default_nettype wire

//--- src/mf_parallel_fir.sv
`timescale 1ns/10ps
`default_nettype none

// parallel FIR for one block per clock
// stage 1 registers every tap product of every lane
// stage 2 adds up each lane's products into a full width sum
module mf_parallel_fir
    import mf_types_pkg::*;
#(
    parameter int NSAMP     = 8,
    parameter int NTAPS     = 8,
    parameter int INBITS    = 12,
    parameter int COEF_BITS = 8,
    parameter int ACC_BITS  = 24
) (
    input  wire logic                               aclk,
    input  wire logic                               arst_n_i,
    input  wire mf_sample_blk_s                     blk_i,
    input  wire logic      [NSAMP-1:0][INBITS-1:0]  prev_i,
    input  wire logic      [NTAPS-1:0][COEF_BITS-1:0] coef_i,
    output mf_acc_blk_s                             acc_o
);

    localparam int PROD_BITS = INBITS + COEF_BITS;

    logic signed [PROD_BITS-1:0] prod_q [NSAMP][NTAPS];
    logic signed [ACC_BITS-1:0]  lane_sum [NSAMP];
    logic signed [ACC_BITS-1:0]  sum_q [NSAMP];
    logic                        vld1_q;
    logic                        vld2_q;

    for (genvar j = 0; j < NSAMP; j++) begin : g_lane
        for (genvar k = 0; k < NTAPS; k++) begin : g_tap
            logic signed [INBITS-1:0] tap_x;

            // lane j tap k wants x[n-k]; it falls into the previous block when j < k
            if (j >= k) begin : g_cur
                assign tap_x = blk_i.samples[j-k];
            end else begin : g_prev
                assign tap_x = prev_i[NSAMP+j-k];
            end

            always_ff @(posedge aclk) begin
                if (blk_i.valid) begin
                    prod_q[j][k] <= tap_x * $signed(coef_i[k]);
                end
            end
        end
    end

    // adder tree per lane, products are sign extended into the sum width
    always_comb begin
        for (int j = 0; j < NSAMP; j++) begin
            lane_sum[j] = '0;
            for (int k = 0; k < NTAPS; k++) begin
                lane_sum[j] = lane_sum[j] + prod_q[j][k];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (vld1_q) begin
            for (int j = 0; j < NSAMP; j++) begin
                sum_q[j] <= lane_sum[j];
            end
        end
    end

    // valid walks alongside the two data stages
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld1_q <= 1'b0;
            vld2_q <= 1'b0;
        end else begin
            vld1_q <= blk_i.valid;
            vld2_q <= vld1_q;
        end
    end

    always_comb begin
        acc_o.valid = vld2_q;
        for (int j = 0; j < NSAMP; j++) begin
            acc_o.sums[j] = sum_q[j];
        end
    end

endmodule

`default_nettype wire

//--- src/mf_round_saturate.sv
`timescale 1ns/10ps
`default_nettype none

// output compression for each lane
// downshift with round half up, pull exact ties back to even,
// then clamp into the signed output range
module mf_round_saturate
    import mf_types_pkg::*;
#(
    parameter int ACC_BITS   = 24,
    parameter int INBITS     = 12,
    parameter int SHIFT_BITS = 4
) (
    input  wire logic                    aclk,
    input  wire logic                    arst_n_i,
    input  wire logic [SHIFT_BITS-1:0]   shift_i,
    input  wire mf_acc_blk_s             acc_i,
    output mf_sample_blk_s               blk_o
);

    localparam int LANES = ($bits(mf_acc_blk_s) - 1) / ACC_BITS;
    // one extra bit so adding the rounding constant cannot wrap
    localparam int WIDE  = ACC_BITS + 1;
    localparam logic signed [WIDE-1:0] MAXV = WIDE'((1 << (INBITS-1)) - 1);
    localparam logic signed [WIDE-1:0] MINV = WIDE'(-(1 << (INBITS-1)));

    logic [LANES-1:0][INBITS-1:0] sat_d;
    logic [LANES-1:0][INBITS-1:0] sat_q;
    logic                         valid_q;

    for (genvar j = 0; j < LANES; j++) begin : g_lane
        logic signed [WIDE-1:0] ext;
        logic signed [WIDE-1:0] half;
        logic signed [WIDE-1:0] frac;
        logic signed [WIDE-1:0] rnd;
        logic                   tie;

        assign ext  = $signed(acc_i.sums[j]);
        assign half = (shift_i == '0) ? '0 : (WIDE'(1) << (shift_i - 1'b1));
        // bits that the shift throws away
        assign frac = ext & ((WIDE'(1) << shift_i) - WIDE'(1));
        assign tie  = (shift_i != '0) && (frac == half);

        always_comb begin
            rnd = (ext + half) >>> shift_i;
            // an exact half rounded up lands on odd, so drop it to even
            if (tie) begin
                rnd[0] = 1'b0;
            end
            if (rnd > MAXV) begin
                sat_d[j] = MAXV[INBITS-1:0];
            end else if (rnd < MINV) begin
                sat_d[j] = MINV[INBITS-1:0];
            end else begin
                sat_d[j] = rnd[INBITS-1:0];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (acc_i.valid) begin
            sat_q <= sat_d;
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= acc_i.valid;
        end
    end

    assign blk_o.valid   = valid_q;
    assign blk_o.samples = sat_q;

endmodule

`default_nettype wire

//--- src/matched_filter_top.sv
`timescale 1ns/10ps
`default_nettype none

// matched filter top level
// input block to output block takes three clocks: two in the FIR, one in rounding
module matched_filter_top
    import mf_types_pkg::*;
#(
    parameter int INBITS     = mf_params_pkg::INBITS,
    parameter int NSAMP      = mf_params_pkg::NSAMP,
    parameter int NTAPS      = mf_params_pkg::NTAPS,
    parameter int COEF_BITS  = mf_params_pkg::COEF_BITS,
    parameter int ACC_BITS   = mf_params_pkg::ACC_BITS,
    parameter int SHIFT_BITS = mf_params_pkg::SHIFT_BITS
) (
    input  wire logic             aclk,
    input  wire logic             arst_n_i,
    input  wire logic             cfg_we_i,
    input  wire mf_cfg_wr_s       cfg_wr_i,
    input  wire mf_sample_blk_s   in_blk_i,
    output mf_sample_blk_s        out_blk_o
);

    logic [NTAPS-1:0][COEF_BITS-1:0] coef;
    logic [SHIFT_BITS-1:0]           shift;
    logic                            hist_clear;
    logic [NSAMP-1:0][INBITS-1:0]    prev_samples;
    mf_sample_blk_s                  win_blk;
    mf_acc_blk_s                     acc_blk;

    mf_coef_regs #(
        .NTAPS      (NTAPS),
        .COEF_BITS  (COEF_BITS),
        .SHIFT_BITS (SHIFT_BITS)
    ) coef_regs_i (
        .aclk     (aclk),
        .arst_n_i (arst_n_i),
        .cfg_we_i (cfg_we_i),
        .cfg_wr_i (cfg_wr_i),
        .coef_o   (coef),
        .shift_o  (shift),
        .clear_o  (hist_clear)
    );

    mf_sample_history #(
        .INBITS (INBITS),
        .NSAMP  (NSAMP)
    ) history_i (
        .aclk     (aclk),
        .arst_n_i (arst_n_i),
        .clear_i  (hist_clear),
        .blk_i    (in_blk_i),
        .prev_o   (prev_samples),
        .blk_o    (win_blk)
    );

    mf_parallel_fir #(
        .NSAMP     (NSAMP),
        .NTAPS     (NTAPS),
        .INBITS    (INBITS),
        .COEF_BITS (COEF_BITS),
        .ACC_BITS  (ACC_BITS)
    ) fir_i (
        .aclk     (aclk),
        .arst_n_i (arst_n_i),
        .blk_i    (win_blk),
        .prev_i   (prev_samples),
        .coef_i   (coef),
        .acc_o    (acc_blk)
    );

    mf_round_saturate #(
        .ACC_BITS   (ACC_BITS),
        .INBITS     (INBITS),
        .SHIFT_BITS (SHIFT_BITS)
    ) round_sat_i (
        .aclk     (aclk),
        .arst_n_i (arst_n_i),
        .shift_i  (shift),
        .acc_i    (acc_blk),
        .blk_o    (out_blk_o)
    );

endmodule

`default_nettype wire

//--- test/matched_filter_checker.sv
`timescale 1ns/10ps
`default_nettype none

// handshake checks on the matched filter top level
module matched_filter_checker (
    input wire logic aclk,
    input wire logic arst_n_i,
    input wire logic in_valid_i,
    input wire logic out_valid_i
);

    // number of failed assertions
    int unsigned fail_cnt = 0;

    // output register is held clear while in reset
    reset_quiet: assert property (@(posedge aclk) !arst_n_i |-> !out_valid_i)
        else begin
            $error("output valid high while reset is asserted");
            fail_cnt++;
        end

    // two FIR stages plus the rounding register
    fixed_latency: assert property (@(posedge aclk) disable iff (!arst_n_i)
        in_valid_i |-> ##3 out_valid_i)
        else begin
            $error("input block did not reach the output three cycles later");
            fail_cnt++;
        end

    no_orphan: assert property (@(posedge aclk) disable iff (!arst_n_i)
        out_valid_i |-> $past(in_valid_i, 3))
        else begin
            $error("output valid without an input block three cycles before");
            fail_cnt++;
        end

endmodule

bind matched_filter_top matched_filter_checker chk_i (
    .aclk        (aclk),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_blk_i.valid),
    .out_valid_i (out_blk_o.valid)
);

`default_nettype wire

//--- test/matched_filter_tb.sv
`timescale 1ns/10ps
`default_nettype none

// testbench for the matched filter top level
module matched_filter_tb
    import mf_params_pkg::*;
    import mf_types_pkg::*;
();

    localparam int NTESTS = 8;
    localparam int PERIOD = 10;
    localparam int SMAX   = (1 << (INBITS - 1)) - 1;
    localparam int SMIN   = -(1 << (INBITS - 1));

    typedef enum {PAT_IMPULSE, PAT_CONST, PAT_RANDOM, PAT_GAPPED} pattern_e;
    typedef logic [NSAMP-1:0][INBITS-1:0] sample_vec_t;

    // one expected output block and the cycle it is due
    typedef struct packed {
        logic [31:0] due;
        logic [7:0]  tidx;
        sample_vec_t samples;
    } exp_blk_s;

    logic           aclk;
    logic           arst_n;
    logic           cfg_we;
    mf_cfg_wr_s     cfg_wr;
    mf_sample_blk_s in_blk;
    mf_sample_blk_s out_blk;

    // stimulus table with one array per column
    string    t_name [NTESTS];
    int       t_coef [NTESTS][NTAPS];
    int       t_shift [NTESTS];
    pattern_e t_pat [NTESTS];
    int       t_nblk [NTESTS];
    bit       t_clear [NTESTS];

    // model of the stored block that reset and clear zero
    longint      model_prev [NSAMP];
    exp_blk_s    exp_q [$];
    exp_blk_s    mon_e;
    int unsigned cyc = 0;
    int          errors = 0;
    int          checks = 0;

    matched_filter_top dut_i (
        .aclk      (aclk),
        .arst_n_i  (arst_n),
        .cfg_we_i  (cfg_we),
        .cfg_wr_i  (cfg_wr),
        .in_blk_i  (in_blk),
        .out_blk_o (out_blk)
    );

    task automatic add_test(input int i, input string name, input int c [NTAPS],
                            input int s, input pattern_e p, input int n, input bit clr);
        t_name[i]  = name;
        t_coef[i]  = c;
        t_shift[i] = s;
        t_pat[i]   = p;
        t_nblk[i]  = n;
        t_clear[i] = clr;
    endtask

    // downshift and round to nearest with ties to even before the clamp
    function automatic logic [INBITS-1:0] round_sat(input longint v, input int s);
        longint q;
        longint half;
        q = v;
        if (s > 0) begin
            half = longint'(1) << (s - 1);
            q = (v + half) >>> s;
            if ((v & ((half << 1) - 1)) == half) begin
                q[0] = 1'b0;
            end
        end
        if (q > SMAX) begin
            q = SMAX;
        end else if (q < SMIN) begin
            q = SMIN;
        end
        return q[INBITS-1:0];
    endfunction

    task automatic write_cfg(input mf_cfg_op_e op, input int idx, input int data);
        @(posedge aclk);
        cfg_we      <= 1'b1;
        cfg_wr.op   <= op;
        cfg_wr.idx  <= 3'(idx);
        cfg_wr.data <= 16'(data);
    endtask

    task automatic send_block(input int t, input sample_vec_t smp);
        exp_blk_s e;
        longint   w [2*NSAMP];
        longint   acc;
        @(posedge aclk);
        in_blk.valid   <= 1'b1;
        in_blk.samples <= smp;
        for (int i = 0; i < NSAMP; i++) begin
            w[i]       = model_prev[i];
            w[NSAMP+i] = $signed(smp[i]);
        end
        // y[n] is the sum of c[k] * x[n-k] over the old block joined to the new one
        for (int j = 0; j < NSAMP; j++) begin
            acc = 0;
            for (int k = 0; k < NTAPS; k++) begin
                acc += t_coef[t][k] * w[NSAMP+j-k];
            end
            e.samples[j] = round_sat(acc, t_shift[t]);
        end
        for (int i = 0; i < NSAMP; i++) begin
            model_prev[i] = w[NSAMP+i];
        end
        // captured at the next edge and loaded into the output register three edges later
        e.due  = 32'(cyc + 4);
        e.tidx = 8'(t);
        exp_q.push_back(e);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge aclk);
        end
        repeat (2) @(posedge aclk);
    endtask

    task automatic run_test(input int t);
        sample_vec_t smp;
        int          gap;
        for (int k = 0; k < NTAPS; k++) begin
            write_cfg(CFG_SET_COEF, k, t_coef[t][k]);
        end
        write_cfg(CFG_SET_SHIFT, 0, t_shift[t]);
        if (t_clear[t]) begin
            write_cfg(CFG_CLEAR_HISTORY, 0, 0);
            model_prev = '{default: 0};
        end
        @(posedge aclk);
        cfg_we <= 1'b0;
        // clear strobe needs one more cycle to reach the history
        repeat (2) @(posedge aclk);
        for (int b = 0; b < t_nblk[t]; b++) begin
            case (t_pat[t])
                PAT_IMPULSE: begin
                    smp = '0;
                    // odd blocks stay empty so the taps walk over the boundary
                    if (b % 2 == 0) begin
                        smp[(b / 2) % NSAMP] = INBITS'(1);
                    end
                end
                PAT_CONST: begin
                    smp = {NSAMP{INBITS'(SMAX)}};
                end
                default: begin
                    for (int j = 0; j < NSAMP; j++) begin
                        smp[j] = INBITS'($urandom);
                    end
                end
            endcase
            if (t_pat[t] == PAT_GAPPED) begin
                gap = $urandom % 3;
                repeat (gap) begin
                    @(posedge aclk);
                    in_blk.valid <= 1'b0;
                    // idle lanes carry junk that the history must not take
                    for (int j = 0; j < NSAMP; j++) begin
                        in_blk.samples[j] <= INBITS'($urandom);
                    end
                end
            end
            send_block(t, smp);
        end
        @(posedge aclk);
        in_blk.valid <= 1'b0;
        wait_drain();
    endtask

    task automatic print_counts();
        $display("errors: %0d, lane checks: %0d", errors, checks);
    endtask

    initial begin
        aclk = 1'b0;
        forever #(PERIOD / 2) aclk = ~aclk;
    end

    // output monitor that compares against the queue of model blocks
    always @(posedge aclk) begin
        cyc <= cyc + 1;
        if (arst_n && out_blk.valid) begin
            if (exp_q.size() == 0) begin
                $display("output valid with no block in flight at cycle %0d", cyc);
                errors++;
            end else begin
                mon_e = exp_q.pop_front();
                if (mon_e.due != cyc) begin
                    $display("%s: output block came at cycle %0d instead of %0d",
                             t_name[mon_e.tidx], cyc, mon_e.due);
                    errors++;
                end
                for (int j = 0; j < NSAMP; j++) begin
                    checks++;
                    if (out_blk.samples[j] !== mon_e.samples[j]) begin
                        $display("mismatch %s lane %0d expected %0d actual %0d",
                                 t_name[mon_e.tidx], j, $signed(mon_e.samples[j]),
                                 $signed(out_blk.samples[j]));
                        errors++;
                    end
                end
            end
        end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
            $display("%s: output valid missing at cycle %0d", t_name[exp_q[0].tidx], cyc);
            mon_e = exp_q.pop_front();
            errors++;
        end
    end

    // watchdog sized from the table
    initial begin
        int budget;
        #1;
        budget = 100;
        for (int t = 0; t < NTESTS; t++) begin
            // a gapped block can take up to three cycles
            budget += 3 * t_nblk[t] + NTAPS + 16;
        end
        #(budget * PERIOD);
        $display("watchdog expired, run did not finish within %0d cycles", budget);
        errors++;
        print_counts();
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h49a7));
        add_test(0, "impulse_lanes", '{12, -25, 37, -50, 63, -76, 89, -128}, 0,
                 PAT_IMPULSE, 16, 1'b0);
        add_test(1, "sat_positive", '{127, 127, 127, 127, 127, 127, 127, 127}, 0,
                 PAT_CONST, 6, 1'b0);
        add_test(2, "sat_negative", '{-128, -128, -128, -128, -128, -128, -128, -128}, 2,
                 PAT_CONST, 6, 1'b0);
        add_test(3, "round_shift1", '{1, 0, 0, 0, 0, 0, 0, 0}, 1, PAT_RANDOM, 12, 1'b0);
        add_test(4, "round_shift3", '{3, -1, 2, 0, 0, 0, 0, 1}, 3, PAT_RANDOM, 12, 1'b0);
        add_test(5, "random_gaps", '{5, -9, 14, -22, 31, -17, 8, -3}, 5, PAT_GAPPED, 24, 1'b0);
        add_test(6, "reload_clear", '{-7, 11, -19, 27, -35, 43, -51, 59}, 6,
                 PAT_RANDOM, 10, 1'b1);
        add_test(7, "back_to_back", '{2, 4, 8, 16, -16, -8, -4, -2}, 2, PAT_RANDOM, 24, 1'b0);
        model_prev = '{default: 0};
        arst_n = 1'b1;
        cfg_we = 1'b0;
        cfg_wr = '0;
        in_blk = '0;
        #1;
        arst_n = 1'b0;
        repeat (4) @(posedge aclk);
        arst_n <= 1'b1;
        for (int t = 0; t < NTESTS; t++) begin
            run_test(t);
        end
        repeat (4) @(posedge aclk);
        errors += dut_i.chk_i.fail_cnt;
        print_counts();
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
src/mf_params_pkg.sv
src/mf_types_pkg.sv
src/mf_coef_regs.sv
src/mf_sample_history.sv
src/mf_parallel_fir.sv
src/mf_round_saturate.sv
src/matched_filter_top.sv
test/matched_filter_checker.sv
test/matched_filter_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the matched filter testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module matched_filter_tb \
    -f all.f

./obj_dir/Vmatched_filter_tb 2>&1 | tee sim.log

# the testbench prints its fail message on any failed check or timeout
if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
